// ==== vlog.f ====
logic/rv_isa_pkg.sv
logic/ooo_cfg_pkg.sv
logic/insn_queue.sv
logic/dispatch.sv
logic/reorder_buffer.sv
logic/reservation_station.sv
logic/ooo_dispatch_top.sv
bench/ooo_dispatch_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the dispatch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module ooo_dispatch_tb -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build did not succeed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

// ==== bench/ooo_dispatch_tb.sv ====
// Testbench for the out-of-order dispatch stage
// LFSR stimulus, in-order rename reference model, execution-unit model,
// immediate assertions and per-test reporting

`timescale 1ns/1ps

module ooo_dispatch_tb import rv_isa_pkg::*, ooo_cfg_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int N_RAND     = 40;
    localparam int N_BP       = 16;
    localparam int N_REG      = 7;
    localparam int MAX_INSN   = 64;
    localparam int WATCHDOG_CYCLES = (N_RAND + N_BP + N_REG) * 60 + 200;
    localparam opcode_t OP_TAB [9] = '{OPCODE_OPIMM, OPCODE_LUI, OPCODE_AUIPC, OPCODE_OP,
        OPCODE_JAL, OPCODE_JALR, OPCODE_BRANCH, OPCODE_LOAD, OPCODE_STORE};

    logic                      clk = 1'b0;
    logic                      rst = 1'b1;
    logic                      push = 1'b0;
    logic [DATA_WIDTH-1:0]     insn_in = '0;
    logic [ADDR_WIDTH-1:0]     iaddr_in = '0;
    logic                      wb_en = 1'b0;
    rob_tag_t                  wb_tag = '0;
    logic [DATA_WIDTH-1:0]     wb_data = '0;
    logic                      insn_full;
    logic                      issue_valid;
    logic [DATA_WIDTH-1:0]     issue_insn;
    logic [ADDR_WIDTH-1:0]     issue_iaddr;
    opcode_t                   issue_opcode;
    rob_tag_t                  issue_dst_tag;
    logic [DATA_WIDTH-1:0]     issue_src1;
    logic [DATA_WIDTH-1:0]     issue_src2;
    logic                      commit_valid;
    rob_op_t                   commit_op;
    logic [REG_ADDR_WIDTH-1:0] commit_rdest;
    logic [DATA_WIDTH-1:0]     commit_data;

    // Reference model, indexed by program order
    rob_op_t               exp_op [MAX_INSN];
    int                    exp_rd [MAX_INSN];
    logic [DATA_WIDTH-1:0] exp_insn [MAX_INSN];
    opcode_t               exp_opc [MAX_INSN];
    int                    prod1  [MAX_INSN];
    int                    prod2  [MAX_INSN];
    logic                  use1   [MAX_INSN];
    logic                  use2   [MAX_INSN];
    logic                  issued [MAX_INSN];
    logic                  done   [MAX_INSN];
    logic [DATA_WIDTH-1:0] wdata  [MAX_INSN];
    int                    last_prod [8];

    // Execution units: issued work waiting for its writeback slot
    int       ex_idx [$];
    int       ex_due [$];
    rob_tag_t ex_tag [$];

    logic [15:0] lfsr = 16'd88;
    int    pushed = 0;
    int    commits = 0;
    int    cycle = 0;
    int    checks = 0;
    int    errors = 0;
    int    test_errs = 0;
    int    tests = 0;
    int    wb_idx = 0;
    logic  long_wb = 1'b0;
    logic  saw_full = 1'b0;
    string test_name = "none";

    ooo_dispatch_top u_dut (
        .clk, .rst, .push, .insn_in, .iaddr_in, .insn_full, .wb_en, .wb_tag, .wb_data,
        .issue_valid, .issue_insn, .issue_iaddr, .issue_opcode, .issue_dst_tag,
        .issue_src1, .issue_src2, .commit_valid, .commit_op, .commit_rdest, .commit_data
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_cond(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("%s: %s", test_name, what);
        end
    endtask

    // Used source takes the latest earlier producer's data, otherwise zero
    task automatic check_source(input int idx, input logic used, input int prod,
                                input logic [31:0] actual, input string what);
        logic [31:0] expected;
        expected = '0;
        if (used && prod >= 0) begin
            check_cond(done[prod], $sformatf("instruction %0d issued before producer %0d wrote back",
                idx, prod));
            expected = wdata[prod];
        end
        check_value(what, expected, actual);
    endtask

    task automatic push_insn(input opcode_t op, input int rd, input int rs1, input int rs2);
        int n;
        n = pushed;
        case (op)
            OPCODE_JAL, OPCODE_JALR, OPCODE_BRANCH: exp_op[n] = ROB_OP_BR;
            OPCODE_LOAD:  exp_op[n] = ROB_OP_LD;
            OPCODE_STORE: exp_op[n] = ROB_OP_STR;
            default:      exp_op[n] = ROB_OP_INT;
        endcase
        exp_rd[n]   = (op == OPCODE_BRANCH || op == OPCODE_STORE) ? 0 : rd;
        exp_insn[n] = {7'b0, 5'(rs2), 5'(rs1), 3'b0, 5'(rd), op};
        exp_opc[n]  = op;
        use1[n]   = !(op == OPCODE_LUI || op == OPCODE_AUIPC || op == OPCODE_JAL);
        use2[n]   = (op == OPCODE_OP || op == OPCODE_BRANCH || op == OPCODE_STORE);
        prod1[n]  = (use1[n] && rs1 != 0) ? last_prod[rs1] : -1;
        prod2[n]  = (use2[n] && rs2 != 0) ? last_prod[rs2] : -1;
        if (exp_rd[n] != 0) begin
            last_prod[rd] = n;
        end
        @(negedge clk);
        while (insn_full) begin
            push = 1'b0;
            @(negedge clk);
        end
        push     = 1'b1;
        insn_in  = exp_insn[n];
        iaddr_in = 32'(n * 4);
        pushed++;
    endtask

    task automatic push_random();
        opcode_t op;
        int      rd;
        int      rs1;
        int      rs2;
        op  = OP_TAB[take_bits(4) % 9];
        rd  = int'(take_bits(3));
        rs1 = int'(take_bits(3));
        rs2 = int'(take_bits(3));
        push_insn(op, rd, rs1, rs2);
    endtask

    task automatic wait_drain();
        @(negedge clk);
        push = 1'b0;
        while (commits != pushed) begin
            @(negedge clk);
        end
    endtask

    task automatic finish_test();
        tests++;
        $display("test %-14s %s (%0d errors)", test_name,
            (errors == test_errs) ? "ok" : "failed", errors - test_errs);
        test_errs = errors;
    endtask

    // Output monitor and result bookkeeping
    always @(posedge clk) begin
        int idx;
        cycle++;
        if (!rst) begin
            if (insn_full) begin
                saw_full = 1'b1;
            end
            if (issue_valid) begin
                idx = int'(issue_iaddr[ADDR_WIDTH-1:2]);
                check_cond(idx < pushed && !issued[idx],
                    $sformatf("unexpected issue of instruction %0d", idx));
                if (idx < pushed) begin
                    issued[idx] = 1'b1;
                    check_value("issue insn", exp_insn[idx], issue_insn);
                    check_value("issue opcode", 32'(exp_opc[idx]), 32'(issue_opcode));
                    // Tags are handed out in program order around the ROB
                    check_value("issue tag", 32'(idx % ROB_DEPTH), 32'(issue_dst_tag));
                    check_source(idx, use1[idx], prod1[idx], issue_src1, "src1");
                    check_source(idx, use2[idx], prod2[idx], issue_src2, "src2");
                    wdata[idx] = take_bits(DATA_WIDTH);
                    ex_idx.push_back(idx);
                    ex_tag.push_back(issue_dst_tag);
                    ex_due.push_back(cycle + int'(take_bits(3) % 6) + (long_wb ? 16 : 0));
                end
            end
            if (commit_valid) begin
                check_cond(commits < pushed && done[commits],
                    $sformatf("commit %0d without a written-back instruction", commits));
                check_value("commit op", 32'(exp_op[commits]), 32'(commit_op));
                check_value("commit rdest", 32'(exp_rd[commits]), 32'(commit_rdest));
                check_value("commit data", wdata[commits], commit_data);
                commits++;
            end
            if (wb_en) begin
                done[wb_idx] = 1'b1;
            end
        end
    end

    // One writeback per cycle, first due entry wins
    always @(negedge clk) begin
        wb_en = 1'b0;
        for (int k = 0; k < ex_idx.size(); k++) begin
            if (ex_due[k] <= cycle) begin
                wb_en   = 1'b1;
                wb_tag  = ex_tag[k];
                wb_idx  = ex_idx[k];
                wb_data = wdata[ex_idx[k]];
                ex_idx.delete(k);
                ex_tag.delete(k);
                ex_due.delete(k);
                break;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired with %0d of %0d instructions committed", commits, pushed);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        for (int r = 0; r < 8; r++) begin
            last_prod[r] = -1;
        end
        for (int i = 0; i < MAX_INSN; i++) begin
            issued[i] = 1'b0;
            done[i]   = 1'b0;
        end
        test_name = "reset";
        repeat (3) begin
            @(negedge clk);
            check_cond(!issue_valid && !commit_valid && !insn_full, "outputs active in reset");
        end
        rst = 1'b0;
        @(negedge clk);
        check_cond(!issue_valid && !commit_valid && !insn_full, "outputs active after reset");
        finish_test();

        test_name = "random_stream";
        for (int i = 0; i < N_RAND; i++) begin
            push_random();
        end
        wait_drain();
        finish_test();

        // Long writeback delays keep the ROB busy so the queue backs up
        test_name = "back_pressure";
        long_wb   = 1'b1;
        saw_full  = 1'b0;
        for (int i = 0; i < N_BP; i++) begin
            push_random();
        end
        wait_drain();
        check_cond(saw_full, "instruction queue never reported full");
        long_wb = 1'b0;
        finish_test();

        test_name = "register_file";
        for (int k = 1; k <= N_REG; k++) begin
            push_insn(OPCODE_OP, 0, k, (k % 7) + 1);
        end
        wait_drain();
        check_cond(!commit_valid && !issue_valid && ex_idx.size() == 0,
            "work left in the DUT after the last commit");
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/ooo_dispatch_top.sv ====
// Dispatch subsystem top level
// Instruction queue, dispatch, reorder buffer and reservation station

`timescale 1ns/1ps

module ooo_dispatch_top import rv_isa_pkg::*, ooo_cfg_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      push,
    input  logic [DATA_WIDTH-1:0]     insn_in,
    input  logic [ADDR_WIDTH-1:0]     iaddr_in,
    output logic                      insn_full,
    input  logic                      wb_en,
    input  rob_tag_t                  wb_tag,
    input  logic [DATA_WIDTH-1:0]     wb_data,
    output logic                      issue_valid,
    output logic [DATA_WIDTH-1:0]     issue_insn,
    output logic [ADDR_WIDTH-1:0]     issue_iaddr,
    output opcode_t                   issue_opcode,
    output rob_tag_t                  issue_dst_tag,
    output logic [DATA_WIDTH-1:0]     issue_src1,
    output logic [DATA_WIDTH-1:0]     issue_src2,
    output logic                      commit_valid,
    output rob_op_t                   commit_op,
    output logic [REG_ADDR_WIDTH-1:0] commit_rdest,
    output logic [DATA_WIDTH-1:0]     commit_data
);

    logic [DATA_WIDTH-1:0]     q_insn;
    logic [ADDR_WIDTH-1:0]     q_iaddr;
    logic                      q_empty;
    logic                      pop;
    logic                      rob_full;
    logic                      rs_full;
    logic                      rob_alloc;
    rob_op_t                   alloc_op;
    logic [REG_ADDR_WIDTH-1:0] alloc_rdest;
    rob_tag_t                  alloc_tag;
    logic [REG_ADDR_WIDTH-1:0] lookup_rs1;
    logic [REG_ADDR_WIDTH-1:0] lookup_rs2;
    rob_tag_t                  src1_tag;
    logic                      src1_rdy;
    logic [DATA_WIDTH-1:0]     src1_data;
    rob_tag_t                  src2_tag;
    logic                      src2_rdy;
    logic [DATA_WIDTH-1:0]     src2_data;
    logic                      rs_insert;
    logic [DATA_WIDTH-1:0]     ins_insn;
    logic [ADDR_WIDTH-1:0]     ins_iaddr;
    opcode_t                   ins_opcode;
    rob_tag_t                  ins_dst_tag;
    rob_tag_t                  ins1_tag;
    logic                      ins1_rdy;
    logic [DATA_WIDTH-1:0]     ins1_data;
    rob_tag_t                  ins2_tag;
    logic                      ins2_rdy;
    logic [DATA_WIDTH-1:0]     ins2_data;

    insn_queue u_queue (
        .clk, .rst, .push, .insn_in, .iaddr_in, .pop,
        .q_insn, .q_iaddr, .q_empty, .insn_full
    );

    dispatch u_dispatch (
        .q_insn, .q_iaddr, .q_empty, .pop, .rob_full, .rs_full,
        .rob_alloc, .alloc_op, .alloc_rdest, .alloc_tag,
        .lookup_rs1, .lookup_rs2,
        .src1_tag, .src1_rdy, .src1_data, .src2_tag, .src2_rdy, .src2_data,
        .rs_insert, .ins_insn, .ins_iaddr, .ins_opcode, .ins_dst_tag,
        .ins1_tag, .ins1_rdy, .ins1_data, .ins2_tag, .ins2_rdy, .ins2_data
    );

    reorder_buffer u_rob (
        .clk, .rst, .rob_alloc, .alloc_op, .alloc_rdest, .alloc_tag, .rob_full,
        .lookup_rs1, .lookup_rs2,
        .src1_tag, .src1_rdy, .src1_data, .src2_tag, .src2_rdy, .src2_data,
        .wb_en, .wb_tag, .wb_data,
        .commit_valid, .commit_op, .commit_rdest, .commit_data
    );

    reservation_station u_rs (
        .clk, .rst, .rs_insert, .ins_insn, .ins_iaddr, .ins_opcode, .ins_dst_tag,
        .ins1_tag, .ins1_rdy, .ins1_data, .ins2_tag, .ins2_rdy, .ins2_data,
        .rs_full, .wb_en, .wb_tag, .wb_data,
        .issue_valid, .issue_insn, .issue_iaddr, .issue_opcode, .issue_dst_tag,
        .issue_src1, .issue_src2
    );

endmodule

// ==== logic/reservation_station.sv ====
// Reservation station
// Entry storage with age stamps, writeback tag capture and oldest-ready issue

`timescale 1ns/1ps

module reservation_station import rv_isa_pkg::*, ooo_cfg_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rs_insert,
    input  logic [DATA_WIDTH-1:0] ins_insn,
    input  logic [ADDR_WIDTH-1:0] ins_iaddr,
    input  opcode_t               ins_opcode,
    input  rob_tag_t              ins_dst_tag,
    input  rob_tag_t              ins1_tag,
    input  logic                  ins1_rdy,
    input  logic [DATA_WIDTH-1:0] ins1_data,
    input  rob_tag_t              ins2_tag,
    input  logic                  ins2_rdy,
    input  logic [DATA_WIDTH-1:0] ins2_data,
    output logic                  rs_full,
    input  logic                  wb_en,
    input  rob_tag_t              wb_tag,
    input  logic [DATA_WIDTH-1:0] wb_data,
    output logic                  issue_valid,
    output logic [DATA_WIDTH-1:0] issue_insn,
    output logic [ADDR_WIDTH-1:0] issue_iaddr,
    output opcode_t               issue_opcode,
    output rob_tag_t              issue_dst_tag,
    output logic [DATA_WIDTH-1:0] issue_src1,
    output logic [DATA_WIDTH-1:0] issue_src2
);

    logic                    valid    [RS_DEPTH];
    logic [RS_IDX_WIDTH-1:0] e_age    [RS_DEPTH];
    logic [DATA_WIDTH-1:0]   e_insn   [RS_DEPTH];
    logic [ADDR_WIDTH-1:0]   e_iaddr  [RS_DEPTH];
    opcode_t                 e_opcode [RS_DEPTH];
    rob_tag_t                e_dst    [RS_DEPTH];
    rob_tag_t                e_tag    [RS_DEPTH][2];
    logic                    e_rdy    [RS_DEPTH][2];
    logic [DATA_WIDTH-1:0]   e_data   [RS_DEPTH][2];

    logic [RS_IDX_WIDTH:0]   occupancy;
    logic [RS_IDX_WIDTH:0]   ins_age;
    logic [RS_IDX_WIDTH-1:0] free_idx;
    logic [RS_IDX_WIDTH-1:0] issue_idx;
    logic [RS_IDX_WIDTH-1:0] issue_age;
    logic                    do_insert;

    // Lowest free slot, occupancy and the oldest entry with both sources ready
    always_comb begin
        occupancy   = '0;
        free_idx    = '0;
        issue_valid = 1'b0;
        issue_idx   = '0;
        issue_age   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            occupancy = occupancy + (RS_IDX_WIDTH+1)'(valid[i]);
            if (!valid[i]) begin
                free_idx = RS_IDX_WIDTH'(i);
            end
            if (valid[i] && e_rdy[i][0] && e_rdy[i][1] &&
                (!issue_valid || e_age[i] < issue_age)) begin
                issue_valid = 1'b1;
                issue_idx   = RS_IDX_WIDTH'(i);
                issue_age   = e_age[i];
            end
        end
    end

    assign rs_full   = (occupancy == (RS_IDX_WIDTH+1)'(RS_DEPTH));
    assign do_insert = rs_insert && !rs_full;
    // Newcomer ranks behind every entry that stays
    assign ins_age   = occupancy - (RS_IDX_WIDTH+1)'(issue_valid);

    assign issue_insn    = e_insn[issue_idx];
    assign issue_iaddr   = e_iaddr[issue_idx];
    assign issue_opcode  = e_opcode[issue_idx];
    assign issue_dst_tag = e_dst[issue_idx];
    assign issue_src1    = e_data[issue_idx][0];
    assign issue_src2    = e_data[issue_idx][1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                valid[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (issue_valid && issue_idx == RS_IDX_WIDTH'(i)) begin
                    valid[i] <= 1'b0;
                end else if (valid[i] && issue_valid && e_age[i] > issue_age) begin
                    e_age[i] <= e_age[i] - 1'b1;
                end
                for (int s = 0; s < 2; s++) begin
                    if (valid[i] && !e_rdy[i][s] && wb_en && e_tag[i][s] == wb_tag) begin
                        e_rdy[i][s]  <= 1'b1;
                        e_data[i][s] <= wb_data;
                    end
                end
            end
            if (do_insert) begin
                valid[free_idx]     <= 1'b1;
                e_age[free_idx]     <= ins_age[RS_IDX_WIDTH-1:0];
                e_insn[free_idx]    <= ins_insn;
                e_iaddr[free_idx]   <= ins_iaddr;
                e_opcode[free_idx]  <= ins_opcode;
                e_dst[free_idx]     <= ins_dst_tag;
                e_tag[free_idx][0]  <= ins1_tag;
                e_rdy[free_idx][0]  <= ins1_rdy;
                e_data[free_idx][0] <= ins1_data;
                e_tag[free_idx][1]  <= ins2_tag;
                e_rdy[free_idx][1]  <= ins2_rdy;
                e_data[free_idx][1] <= ins2_data;
            end
        end
    end

endmodule

// ==== logic/reorder_buffer.sv ====
// Reorder buffer
// Tag allocation, register rename map, source lookup with writeback bypass,
// result writeback and in-order commit into the register file

`timescale 1ns/1ps

module reorder_buffer import ooo_cfg_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rob_alloc,
    input  rob_op_t                   alloc_op,
    input  logic [REG_ADDR_WIDTH-1:0] alloc_rdest,
    output rob_tag_t                  alloc_tag,
    output logic                      rob_full,
    input  logic [REG_ADDR_WIDTH-1:0] lookup_rs1,
    input  logic [REG_ADDR_WIDTH-1:0] lookup_rs2,
    output rob_tag_t                  src1_tag,
    output logic                      src1_rdy,
    output logic [DATA_WIDTH-1:0]     src1_data,
    output rob_tag_t                  src2_tag,
    output logic                      src2_rdy,
    output logic [DATA_WIDTH-1:0]     src2_data,
    input  logic                      wb_en,
    input  rob_tag_t                  wb_tag,
    input  logic [DATA_WIDTH-1:0]     wb_data,
    output logic                      commit_valid,
    output rob_op_t                   commit_op,
    output logic [REG_ADDR_WIDTH-1:0] commit_rdest,
    output logic [DATA_WIDTH-1:0]     commit_data
);

    localparam int NUM_REGS = 2 ** REG_ADDR_WIDTH;

    rob_op_t                   ent_op    [ROB_DEPTH];
    logic [REG_ADDR_WIDTH-1:0] ent_rdest [ROB_DEPTH];
    logic                      ent_done  [ROB_DEPTH];
    logic [DATA_WIDTH-1:0]     ent_data  [ROB_DEPTH];
    rob_tag_t                  head;
    rob_tag_t                  tail;
    logic [ROB_CNT_WIDTH-1:0]  count;

    logic                      map_valid [NUM_REGS];
    rob_tag_t                  map_tag   [NUM_REGS];
    logic [DATA_WIDTH-1:0]     regfile   [NUM_REGS];

    logic [REG_ADDR_WIDTH-1:0] lk_reg  [2];
    rob_tag_t                  lk_tag  [2];
    logic                      lk_rdy  [2];
    logic [DATA_WIDTH-1:0]     lk_data [2];
    logic                      do_alloc;

    assign alloc_tag = tail;
    assign rob_full  = (count == ROB_CNT_WIDTH'(ROB_DEPTH));
    assign do_alloc  = rob_alloc && !rob_full;

    assign commit_valid = (count != '0) && ent_done[head];
    assign commit_op    = ent_op[head];
    assign commit_rdest = ent_rdest[head];
    assign commit_data  = ent_data[head];

    assign lk_reg[0] = lookup_rs1;
    assign lk_reg[1] = lookup_rs2;

    // Register file, finished entry, same-cycle writeback, or wait on the tag
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            lk_tag[s]  = map_tag[lk_reg[s]];
            lk_rdy[s]  = 1'b1;
            lk_data[s] = regfile[lk_reg[s]];
            if (lk_reg[s] != '0 && map_valid[lk_reg[s]]) begin
                if (ent_done[lk_tag[s]]) begin
                    lk_data[s] = ent_data[lk_tag[s]];
                end else if (wb_en && wb_tag == lk_tag[s]) begin
                    lk_data[s] = wb_data;
                end else begin
                    lk_rdy[s]  = 1'b0;
                    lk_data[s] = '0;
                end
            end
        end
    end

    assign src1_tag  = lk_tag[0];
    assign src1_rdy  = lk_rdy[0];
    assign src1_data = lk_data[0];
    assign src2_tag  = lk_tag[1];
    assign src2_rdy  = lk_rdy[1];
    assign src2_data = lk_data[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                ent_done[i] <= 1'b0;
            end
            for (int r = 0; r < NUM_REGS; r++) begin
                map_valid[r] <= 1'b0;
                regfile[r]   <= '0;
            end
        end else begin
            if (wb_en) begin
                ent_done[wb_tag] <= 1'b1;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
                if (commit_rdest != '0 && commit_op != ROB_OP_STR) begin
                    regfile[commit_rdest] <= commit_data;
                end
                if (map_valid[commit_rdest] && map_tag[commit_rdest] == head) begin
                    map_valid[commit_rdest] <= 1'b0;
                end
            end
            // Allocation comes last so a new producer keeps the map entry
            if (do_alloc) begin
                tail           <= tail + 1'b1;
                ent_done[tail] <= 1'b0;
                if (alloc_rdest != '0) begin
                    map_valid[alloc_rdest] <= 1'b1;
                    map_tag[alloc_rdest]   <= tail;
                end
            end
            count <= count + ROB_CNT_WIDTH'(do_alloc) - ROB_CNT_WIDTH'(commit_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (do_alloc) begin
            ent_op[tail]    <= alloc_op;
            ent_rdest[tail] <= alloc_rdest;
        end
        if (wb_en) begin
            ent_data[wb_tag] <= wb_data;
        end
    end

endmodule

// ==== logic/dispatch.sv ====
// Dispatch stage
// Opcode decode and classification, ROB allocation, source rename lookup
// and reservation station insertion

`timescale 1ns/1ps

module dispatch import rv_isa_pkg::*, ooo_cfg_pkg::*; (
    input  logic [DATA_WIDTH-1:0]     q_insn,
    input  logic [ADDR_WIDTH-1:0]     q_iaddr,
    input  logic                      q_empty,
    output logic                      pop,
    input  logic                      rob_full,
    input  logic                      rs_full,
    output logic                      rob_alloc,
    output rob_op_t                   alloc_op,
    output logic [REG_ADDR_WIDTH-1:0] alloc_rdest,
    input  rob_tag_t                  alloc_tag,
    output logic [REG_ADDR_WIDTH-1:0] lookup_rs1,
    output logic [REG_ADDR_WIDTH-1:0] lookup_rs2,
    input  rob_tag_t                  src1_tag,
    input  logic                      src1_rdy,
    input  logic [DATA_WIDTH-1:0]     src1_data,
    input  rob_tag_t                  src2_tag,
    input  logic                      src2_rdy,
    input  logic [DATA_WIDTH-1:0]     src2_data,
    output logic                      rs_insert,
    output logic [DATA_WIDTH-1:0]     ins_insn,
    output logic [ADDR_WIDTH-1:0]     ins_iaddr,
    output opcode_t                   ins_opcode,
    output rob_tag_t                  ins_dst_tag,
    output rob_tag_t                  ins1_tag,
    output logic                      ins1_rdy,
    output logic [DATA_WIDTH-1:0]     ins1_data,
    output rob_tag_t                  ins2_tag,
    output logic                      ins2_rdy,
    output logic [DATA_WIDTH-1:0]     ins2_data
);

    opcode_t                   opcode;
    logic [REG_ADDR_WIDTH-1:0] rdest;
    logic                      keep_rd;
    logic                      use_rs1;
    logic                      use_rs2;
    logic                      enable;

    assign opcode     = q_insn[$bits(opcode_t)-1:0];
    assign rdest      = q_insn[RD_LSB +: REG_ADDR_WIDTH];
    assign lookup_rs1 = q_insn[RS1_LSB +: REG_ADDR_WIDTH];
    assign lookup_rs2 = q_insn[RS2_LSB +: REG_ADDR_WIDTH];

    // One enable for queue, ROB and reservation station
    assign enable    = !q_empty && !rob_full && !rs_full;
    assign pop       = enable;
    assign rob_alloc = enable;
    assign rs_insert = enable;

    // Class, destination use and source use per opcode
    always_comb begin
        ins_opcode = opcode;
        keep_rd    = 1'b1;
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        alloc_op   = ROB_OP_INT;
        case (opcode)
            OPCODE_OPIMM:  use_rs1 = 1'b1;
            OPCODE_LUI,
            OPCODE_AUIPC:  ;
            OPCODE_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OPCODE_JAL:    alloc_op = ROB_OP_BR;
            OPCODE_JALR: begin
                alloc_op = ROB_OP_BR;
                use_rs1  = 1'b1;
            end
            OPCODE_BRANCH: begin
                alloc_op = ROB_OP_BR;
                keep_rd  = 1'b0;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
            end
            OPCODE_LOAD: begin
                alloc_op = ROB_OP_LD;
                use_rs1  = 1'b1;
            end
            OPCODE_STORE: begin
                alloc_op = ROB_OP_STR;
                keep_rd  = 1'b0;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
            end
            default: begin
                // Unknown opcode goes down as an integer no-op
                ins_opcode = OPCODE_OPIMM;
                keep_rd    = 1'b0;
            end
        endcase
    end

    assign alloc_rdest = keep_rd ? rdest : '0;

    assign ins_insn    = q_insn;
    assign ins_iaddr   = q_iaddr;
    assign ins_dst_tag = alloc_tag;

    // Unused sources enter the station ready with zero data
    assign ins1_tag  = use_rs1 ? src1_tag : '0;
    assign ins1_rdy  = use_rs1 ? src1_rdy : 1'b1;
    assign ins1_data = use_rs1 ? src1_data : '0;
    assign ins2_tag  = use_rs2 ? src2_tag : '0;
    assign ins2_rdy  = use_rs2 ? src2_rdy : 1'b1;
    assign ins2_data = use_rs2 ? src2_data : '0;

endmodule

// ==== logic/insn_queue.sv ====
// Instruction queue
// Circular buffer of instruction word and fetch address with full and empty levels

`timescale 1ns/1ps

module insn_queue import ooo_cfg_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  logic [DATA_WIDTH-1:0] insn_in,
    input  logic [ADDR_WIDTH-1:0] iaddr_in,
    input  logic                  pop,
    output logic [DATA_WIDTH-1:0] q_insn,
    output logic [ADDR_WIDTH-1:0] q_iaddr,
    output logic                  q_empty,
    output logic                  insn_full
);

    logic [DATA_WIDTH-1:0]   insn_mem  [IQ_DEPTH];
    logic [ADDR_WIDTH-1:0]   iaddr_mem [IQ_DEPTH];
    logic [IQ_PTR_WIDTH-1:0] wr_ptr;
    logic [IQ_PTR_WIDTH-1:0] rd_ptr;
    logic [IQ_CNT_WIDTH-1:0] count;
    logic                    do_push;
    logic                    do_pop;

    assign q_empty   = (count == '0);
    assign insn_full = (count == IQ_CNT_WIDTH'(IQ_DEPTH));
    assign do_push   = push && !insn_full;
    assign do_pop    = pop && !q_empty;

    // Head entry is visible without a read cycle
    assign q_insn  = insn_mem[rd_ptr];
    assign q_iaddr = iaddr_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == IQ_PTR_WIDTH'(IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == IQ_PTR_WIDTH'(IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + IQ_CNT_WIDTH'(do_push) - IQ_CNT_WIDTH'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            insn_mem[wr_ptr]  <= insn_in;
            iaddr_mem[wr_ptr] <= iaddr_in;
        end
    end

endmodule

// ==== logic/ooo_cfg_pkg.sv ====
// Core sizing for the dispatch stage
// Data and address widths, buffer depths, ROB tag and ROB operation class

package ooo_cfg_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int ADDR_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;

    localparam int ROB_DEPTH     = 8;
    localparam int TAG_WIDTH     = 3;
    localparam int ROB_CNT_WIDTH = TAG_WIDTH + 1;

    localparam int RS_DEPTH     = 4;
    localparam int RS_IDX_WIDTH = $clog2(RS_DEPTH);

    localparam int IQ_DEPTH     = 4;
    localparam int IQ_PTR_WIDTH = $clog2(IQ_DEPTH);
    localparam int IQ_CNT_WIDTH = $clog2(IQ_DEPTH + 1);

    typedef logic [TAG_WIDTH-1:0] rob_tag_t;

    // Class of the instruction as seen at commit
    typedef enum logic [1:0] {
        ROB_OP_INT,
        ROB_OP_BR,
        ROB_OP_LD,
        ROB_OP_STR
    } rob_op_t;

endpackage

// ==== logic/rv_isa_pkg.sv ====
// RV32I major opcode encodings
// Register field positions inside an instruction word

package rv_isa_pkg;

    typedef logic [6:0] opcode_t;

    localparam opcode_t OPCODE_OPIMM  = 7'b0010011;
    localparam opcode_t OPCODE_LUI    = 7'b0110111;
    localparam opcode_t OPCODE_AUIPC  = 7'b0010111;
    localparam opcode_t OPCODE_OP     = 7'b0110011;
    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_JALR   = 7'b1100111;
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;
    localparam opcode_t OPCODE_LOAD   = 7'b0000011;
    localparam opcode_t OPCODE_STORE  = 7'b0100011;

    // Low bit of each register field
    localparam int RD_LSB  = 7;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;

endpackage
